// File: axi_bridge_cfg.svh
`ifndef AXI_BRIDGE_CFG_SVH
`define AXI_BRIDGE_CFG_SVH

// Byte address width on both the AXI and AXI-Lite sides
`define AXI_ADDR_W 8

// Data width, strobe is one bit per byte
`define AXI_DATA_W 32
`define AXI_STRB_W (`AXI_DATA_W / 8)

// Transaction ID and user sideband widths
`define AXI_ID_W 4
`define AXI_USER_W 1

// Up to 2**OUTSTANDING_W writes in flight without a response
`define OUTSTANDING_W 2

// Number of 32-bit words in the register bank
`define REG_COUNT 16

`endif

// File: axi_lite_pkg.sv
`default_nettype none

`include "axi_bridge_cfg.svh"

package axi_lite_pkg;

  // Write response codes, only the two the bank returns
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // AXI-Lite write address
  typedef struct packed {
    logic [`AXI_ADDR_W-1:0] addr;
  } axil_aw_t;

  // AXI-Lite write data
  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
  } axil_w_t;

  // AXI-Lite write response
  typedef struct packed {
    axi_resp_e resp;
  } axil_b_t;

endpackage

`default_nettype wire

// File: axi_full_pkg.sv
`default_nettype none

`include "axi_bridge_cfg.svh"

package axi_full_pkg;

  import axi_lite_pkg::*;

  // Full AXI write address, burst fields kept for protocol shape
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    logic [1:0]             burst;
    logic [`AXI_USER_W-1:0] user;
  } axi_aw_t;

  // Full AXI write data beat
  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
    logic                   last;
  } axi_w_t;

  // Full AXI write response
  // Same response code as the AXI-Lite side
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    axi_resp_e              resp;
    logic [`AXI_USER_W-1:0] user;
  } axi_b_t;

endpackage

`default_nettype wire

// File: skid_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module skid_buffer #(
  parameter int DATA_W = 8
) (
  input  wire logic              clk,
  input  wire logic              i_rst,
  input  wire logic              i_valid,
  input  wire logic [DATA_W-1:0] i_data,
  output logic                   o_ready,
  output logic                   o_valid,
  output logic [DATA_W-1:0]      o_data,
  input  wire logic              i_ready
);

  logic              out_valid;
  logic [DATA_W-1:0] out_data;
  logic              spill_valid;
  logic [DATA_W-1:0] spill_data;
  logic              in_push;
  logic              out_free;

  // Ready only depends on the spill flop
  assign o_ready  = !spill_valid;
  assign in_push  = i_valid && o_ready;
  // Output slot can take a new item this cycle
  assign out_free = !out_valid || i_ready;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      out_valid   <= 1'b0;
      spill_valid <= 1'b0;
    end else if (out_free) begin
      // Spill drains first, input is blocked while it is full
      out_valid   <= spill_valid || in_push;
      spill_valid <= 1'b0;
    end else if (in_push) begin
      spill_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      out_data <= spill_valid ? spill_data : i_data;
    end
    if (!out_free && in_push) begin
      spill_data <= i_data;
    end
  end

  assign o_valid = out_valid;
  assign o_data  = out_data;

endmodule

`default_nettype wire

// File: id_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module id_fifo #(
  parameter int ADDR_W = 2,
  parameter int DATA_W = 8
) (
  input  wire logic              clk,
  input  wire logic              i_rst,
  input  wire logic              i_push,
  input  wire logic [DATA_W-1:0] i_data,
  output logic                   o_full,
  input  wire logic              i_pop,
  output logic [DATA_W-1:0]      o_data,
  output logic                   o_empty
);

  localparam int DEPTH = 2 ** ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];
  // Extra MSB tells full from empty
  logic [ADDR_W:0]   wr_ptr;
  logic [ADDR_W:0]   rd_ptr;
  logic              bypass;
  logic              do_push;
  logic              do_pop;

  assign o_empty = (wr_ptr == rd_ptr);
  assign o_full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  // Empty FIFO with push and pop together passes the entry straight through
  assign bypass  = o_empty && i_push && i_pop;
  assign do_push = i_push && !o_full && !bypass;
  assign do_pop  = i_pop && !o_empty;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[ADDR_W-1:0]] <= i_data;
    end
  end

  // Head shows the incoming word when nothing is stored
  assign o_data = o_empty ? i_data : mem[rd_ptr[ADDR_W-1:0]];

endmodule

`default_nettype wire

// File: axi_axil_reflect_wr.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_bridge_cfg.svh"

module axi_axil_reflect_wr import axi_lite_pkg::*, axi_full_pkg::*; (
  input  wire logic     clk,
  input  wire logic     i_rst,
  input  wire axi_aw_t  i_aw,
  input  wire logic     i_aw_valid,
  output logic          o_aw_ready,
  input  wire axi_w_t   i_w,
  input  wire logic     i_w_valid,
  output logic          o_w_ready,
  output axi_b_t        o_b,
  output logic          o_b_valid,
  input  wire logic     i_b_ready,
  output axil_aw_t      o_axil_aw,
  output logic          o_axil_aw_valid,
  input  wire logic     i_axil_aw_ready,
  output axil_w_t       o_axil_w,
  output logic          o_axil_w_valid,
  input  wire logic     i_axil_w_ready,
  input  wire axil_b_t  i_axil_b,
  input  wire logic     i_axil_b_valid,
  output logic          o_axil_b_ready
);

  // ID and user of one accepted request
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_USER_W-1:0] user;
  } id_tag_t;

  logic     aw_sb_ready;
  logic     w_sb_ready;
  logic     fifo_full;
  logic     fifo_empty;
  id_tag_t  tag_in;
  id_tag_t  tag_head;
  axil_aw_t aw_in;
  axil_w_t  w_in;
  logic     unused_bits;

  assign tag_in = '{id: i_aw.id, user: i_aw.user};
  assign aw_in  = '{addr: i_aw.addr};
  assign w_in   = '{data: i_w.data, strb: i_w.strb};

  skid_buffer #(.DATA_W($bits(axil_aw_t))) u_aw_sb (
    .clk, .i_rst,
    .i_valid(i_aw_valid && o_aw_ready), .i_data(aw_in), .o_ready(aw_sb_ready),
    .o_valid(o_axil_aw_valid), .o_data(o_axil_aw), .i_ready(i_axil_aw_ready)
  );

  skid_buffer #(.DATA_W($bits(axil_w_t))) u_w_sb (
    .clk, .i_rst,
    .i_valid(i_w_valid && o_w_ready), .i_data(w_in), .o_ready(w_sb_ready),
    .o_valid(o_axil_w_valid), .o_data(o_axil_w), .i_ready(i_axil_w_ready)
  );

  // Tags leave in the order the addresses came in
  id_fifo #(.ADDR_W(`OUTSTANDING_W), .DATA_W($bits(id_tag_t))) u_id_fifo (
    .clk, .i_rst,
    .i_push(i_aw_valid && o_aw_ready), .i_data(tag_in), .o_full(fifo_full),
    .i_pop(o_b_valid && i_b_ready), .o_data(tag_head), .o_empty(fifo_empty)
  );

  // Full FIFO stops both channels to cap outstanding writes
  assign o_aw_ready = aw_sb_ready && !fifo_full;
  assign o_w_ready  = w_sb_ready && !fifo_full;

  assign o_b_valid      = i_axil_b_valid;
  assign o_b            = '{id: tag_head.id, resp: i_axil_b.resp, user: tag_head.user};
  assign o_axil_b_ready = i_b_ready;

  // Burst shape is fixed at one beat, so these bits are dropped
  assign unused_bits = ^{i_aw.len, i_aw.size, i_aw.burst, i_w.last, fifo_empty};

endmodule

`default_nettype wire

// File: axil_reg_bank.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_bridge_cfg.svh"

module axil_reg_bank import axi_lite_pkg::*; (
  input  wire logic                         clk,
  input  wire logic                         i_rst,
  input  wire axil_aw_t                     i_aw,
  input  wire logic                         i_aw_valid,
  output logic                              o_aw_ready,
  input  wire axil_w_t                      i_w,
  input  wire logic                         i_w_valid,
  output logic                              o_w_ready,
  output axil_b_t                           o_b,
  output logic                              o_b_valid,
  input  wire logic                         i_b_ready,
  input  wire logic [$clog2(`REG_COUNT)-1:0] i_dbg_idx,
  output logic [`AXI_DATA_W-1:0]            o_dbg_data
);

  localparam int IDX_W = $clog2(`REG_COUNT);
  // First byte address past the bank
  localparam logic [`AXI_ADDR_W:0] LIMIT = (`AXI_ADDR_W + 1)'(`REG_COUNT * 4);

  logic [`AXI_DATA_W-1:0] regs [`REG_COUNT];
  logic                   accept;
  logic                   in_range;
  logic [IDX_W-1:0]       wr_idx;
  logic                   b_valid;
  axi_resp_e              b_resp;

  // Both channels go in together, one write at a time
  assign accept     = i_aw_valid && i_w_valid && !b_valid;
  assign o_aw_ready = accept;
  assign o_w_ready  = accept;

  assign in_range = {1'b0, i_aw.addr} < LIMIT;
  assign wr_idx   = i_aw.addr[IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (accept && in_range) begin
      // Byte lane merge
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        if (i_w.strb[b]) begin
          regs[wr_idx][8*b +: 8] <= i_w.data[8*b +: 8];
        end
      end
    end
  end

  // Response held until the manager takes it
  always_ff @(posedge clk) begin
    if (i_rst) begin
      b_valid <= 1'b0;
    end else if (accept) begin
      b_valid <= 1'b1;
    end else if (i_b_ready) begin
      b_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      b_resp <= in_range ? OKAY : SLVERR;
    end
  end

  assign o_b_valid = b_valid;
  assign o_b       = '{resp: b_resp};

  assign o_dbg_data = regs[i_dbg_idx];

endmodule

`default_nettype wire

// File: axi_wr_bridge_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_bridge_cfg.svh"

module axi_wr_bridge_top import axi_lite_pkg::*, axi_full_pkg::*; (
  input  wire logic                         clk,
  input  wire logic                         i_rst,
  input  wire axi_aw_t                      i_aw,
  input  wire logic                         i_aw_valid,
  output logic                              o_aw_ready,
  input  wire axi_w_t                       i_w,
  input  wire logic                         i_w_valid,
  output logic                              o_w_ready,
  output axi_b_t                            o_b,
  output logic                              o_b_valid,
  input  wire logic                         i_b_ready,
  input  wire logic [$clog2(`REG_COUNT)-1:0] i_dbg_idx,
  output logic [`AXI_DATA_W-1:0]            o_dbg_data
);

  // AXI-Lite link between bridge and bank
  axil_aw_t axil_aw;
  logic     axil_aw_valid;
  logic     axil_aw_ready;
  axil_w_t  axil_w;
  logic     axil_w_valid;
  logic     axil_w_ready;
  axil_b_t  axil_b;
  logic     axil_b_valid;
  logic     axil_b_ready;

  axi_axil_reflect_wr u_bridge (
    .clk, .i_rst,
    .i_aw, .i_aw_valid, .o_aw_ready,
    .i_w, .i_w_valid, .o_w_ready,
    .o_b, .o_b_valid, .i_b_ready,
    .o_axil_aw(axil_aw), .o_axil_aw_valid(axil_aw_valid), .i_axil_aw_ready(axil_aw_ready),
    .o_axil_w(axil_w), .o_axil_w_valid(axil_w_valid), .i_axil_w_ready(axil_w_ready),
    .i_axil_b(axil_b), .i_axil_b_valid(axil_b_valid), .o_axil_b_ready(axil_b_ready)
  );

  axil_reg_bank u_regs (
    .clk, .i_rst,
    .i_aw(axil_aw), .i_aw_valid(axil_aw_valid), .o_aw_ready(axil_aw_ready),
    .i_w(axil_w), .i_w_valid(axil_w_valid), .o_w_ready(axil_w_ready),
    .o_b(axil_b), .o_b_valid(axil_b_valid), .i_b_ready(axil_b_ready),
    .i_dbg_idx, .o_dbg_data
  );

endmodule

`default_nettype wire

// File: tb_axi_wr_bridge.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_bridge_cfg.svh"

module tb_axi_wr_bridge
  import axi_lite_pkg::*, axi_full_pkg::*;
();

  localparam int TIMEOUT = 200;
  localparam logic [31:0] SEED = 32'h34f9c0b4;

  logic                          clk = 1'b0;
  logic                          i_rst;
  axi_aw_t                       i_aw;
  logic                          i_aw_valid;
  logic                          o_aw_ready;
  axi_w_t                        i_w;
  logic                          i_w_valid;
  logic                          o_w_ready;
  axi_b_t                        o_b;
  logic                          o_b_valid;
  logic                          i_b_ready;
  logic [$clog2(`REG_COUNT)-1:0] i_dbg_idx;
  logic [`AXI_DATA_W-1:0]        o_dbg_data;

  logic [31:0]            lfsr;
  int                     b_mode;
  int                     mode_now;
  logic                   post_rst;
  logic                   dbg_check;
  logic [`AXI_DATA_W-1:0] dbg_exp;
  logic [`AXI_DATA_W-1:0] model [`REG_COUNT];
  axi_b_t                 sb_q [$];
  axi_b_t                 exp_b;
  int                     sb_count;
  axi_aw_t                aw_list [$];
  axi_w_t                 w_list [$];
  int                     aw_gap [$];
  int                     w_gap [$];
  int                     resp_errs = 0;
  int                     reg_errs = 0;
  int                     proto_errs = 0;
  int                     timeouts = 0;

  axi_wr_bridge_top UUT (
    .clk, .i_rst,
    .i_aw, .i_aw_valid, .o_aw_ready,
    .i_w, .i_w_valid, .o_w_ready,
    .o_b, .o_b_valid, .i_b_ready,
    .i_dbg_idx, .o_dbg_data
  );

  always #20 clk = ~clk;

  // Galois LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Response the bank owes for this address
  function automatic axi_b_t expect_b(input axi_aw_t aw);
    axi_b_t b;
    b.id   = aw.id;
    b.user = aw.user;
    b.resp = (int'(aw.addr) < `REG_COUNT * 4) ? OKAY : SLVERR;
    return b;
  endfunction

  // Scoreboard keeps one entry per accepted address
  always @(posedge clk) begin
    if (i_rst) begin
      sb_q.delete();
    end else begin
      if (o_b_valid && i_b_ready && sb_q.size() > 0) begin
        void'(sb_q.pop_front());
      end
      if (i_aw_valid && o_aw_ready) begin
        sb_q.push_back(expect_b(i_aw));
      end
    end
    if (sb_q.size() > 0) begin
      exp_b <= sb_q[0];
    end else begin
      exp_b <= '0;
    end
    sb_count <= sb_q.size();
  end

  // Mode 2 stalls B ready about one cycle in four
  always @(posedge clk) begin
    mode_now = b_mode;
    #2;
    if (mode_now == 0) begin
      i_b_ready = 1'b1;
    end else if (mode_now == 1) begin
      i_b_ready = 1'b0;
    end else begin
      i_b_ready = (rand_bits(2) != 0);
    end
  end

  assert property (@(posedge clk) disable iff (i_rst)
    post_rst |-> !o_b_valid && o_aw_ready && o_w_ready)
    else begin
      proto_errs++;
      $display("Error: after reset o_b_valid %h o_aw_ready %h o_w_ready %h",
               $sampled(o_b_valid), $sampled(o_aw_ready), $sampled(o_w_ready));
    end

  assert property (@(posedge clk) disable iff (i_rst)
    o_b_valid && i_b_ready |-> o_b.id == exp_b.id)
    else begin
      resp_errs++;
      $display("Error: o_b.id got %h expected %h", $sampled(o_b.id), $sampled(exp_b.id));
    end

  assert property (@(posedge clk) disable iff (i_rst)
    o_b_valid && i_b_ready |-> o_b.user == exp_b.user)
    else begin
      resp_errs++;
      $display("Error: o_b.user got %h expected %h", $sampled(o_b.user), $sampled(exp_b.user));
    end

  assert property (@(posedge clk) disable iff (i_rst)
    o_b_valid && i_b_ready |-> o_b.resp == exp_b.resp)
    else begin
      resp_errs++;
      $display("Error: o_b.resp got %h expected %h", $sampled(o_b.resp), $sampled(exp_b.resp));
    end

  assert property (@(posedge clk) disable iff (i_rst) o_b_valid |-> sb_count != 0)
    else begin
      proto_errs++;
      $display("Error: o_b_valid %h with outstanding count %h", $sampled(o_b_valid),
               $sampled(sb_count));
    end

  assert property (@(posedge clk) disable iff (i_rst) sb_count <= 4)
    else begin
      proto_errs++;
      $display("Error: outstanding count %h above 4", $sampled(sb_count));
    end

  assert property (@(posedge clk) disable iff (i_rst) dbg_check |-> o_dbg_data == dbg_exp)
    else begin
      reg_errs++;
      $display("Error: o_dbg_data[%0d] got %h expected %h", $sampled(i_dbg_idx),
               $sampled(o_dbg_data), $sampled(dbg_exp));
    end

  // Queue one write and apply it to the model right away
  function automatic void queue_write(input logic [7:0] addr, input logic [31:0] data,
                                      input logic [3:0] strb, input logic [3:0] id,
                                      input logic user, input int gap_aw, input int gap_w);
    aw_list.push_back('{id: id, addr: addr, len: 8'd0, size: 3'd2, burst: 2'b01, user: user});
    w_list.push_back('{data: data, strb: strb, last: 1'b1});
    aw_gap.push_back(gap_aw);
    w_gap.push_back(gap_w);
    if (int'(addr) < `REG_COUNT * 4) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          model[addr / 4][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
  endfunction

  task automatic send_aw(input axi_aw_t aw);
    int   waited;
    logic taken;
    waited     = 0;
    taken      = 1'b0;
    i_aw       = aw;
    i_aw_valid = 1'b1;
    while (!taken && waited < TIMEOUT) begin
      @(negedge clk);
      taken = o_aw_ready;
      @(posedge clk);
      #2;
      waited++;
    end
    i_aw_valid = 1'b0;
    if (!taken) begin
      timeouts++;
      $display("Write address was never accepted, id %h", aw.id);
    end
  endtask

  task automatic send_w(input axi_w_t w);
    int   waited;
    logic taken;
    waited    = 0;
    taken     = 1'b0;
    i_w       = w;
    i_w_valid = 1'b1;
    while (!taken && waited < TIMEOUT) begin
      @(negedge clk);
      taken = o_w_ready;
      @(posedge clk);
      #2;
      waited++;
    end
    i_w_valid = 1'b0;
    if (!taken) begin
      timeouts++;
      $display("Write data was never accepted");
    end
  endtask

  task automatic drive_aw();
    while (aw_list.size() > 0) begin
      send_aw(aw_list.pop_front());
      repeat (aw_gap.pop_front()) begin
        @(posedge clk);
        #2;
      end
    end
  endtask

  task automatic drive_w();
    while (w_list.size() > 0) begin
      send_w(w_list.pop_front());
      repeat (w_gap.pop_front()) begin
        @(posedge clk);
        #2;
      end
    end
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (sb_q.size() != 0 && waited < TIMEOUT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (sb_q.size() != 0) begin
      timeouts++;
      $display("Writes left without a response: %0d", sb_q.size());
    end
  endtask

  task automatic run_queued();
    fork
      drive_aw();
      drive_w();
    join
    wait_idle();
  endtask

  // Walk the debug port over every register
  task automatic check_regs();
    for (int i = 0; i < `REG_COUNT; i++) begin
      i_dbg_idx = 4'(i);
      dbg_exp   = model[i];
      dbg_check = 1'b1;
      @(posedge clk);
      #2;
    end
    dbg_check = 1'b0;
  endtask

  initial begin
    #5_000_000;
    $display("Simulation ran past its time limit");
    $display("test failed");
    $finish;
  end

  initial begin
    logic [7:0] addr;
    i_rst      = 1'b1;
    i_aw       = '0;
    i_aw_valid = 1'b0;
    i_w        = '0;
    i_w_valid  = 1'b0;
    i_b_ready  = 1'b0;
    i_dbg_idx  = '0;
    dbg_check  = 1'b0;
    dbg_exp    = '0;
    post_rst   = 1'b0;
    b_mode     = 0;
    lfsr       = SEED;
    for (int i = 0; i < `REG_COUNT; i++) begin
      model[i] = '0;
    end
    repeat (4) begin
      @(posedge clk);
      #2;
    end
    i_rst    = 1'b0;
    post_rst = 1'b1;
    @(posedge clk);
    #2;
    post_rst = 1'b0;
    check_regs();

    // Full word then a partial strobe over it
    queue_write(8'h14, 32'hdeadbeef, 4'hf, 4'h5, 1'b1, 0, 0);
    run_queued();
    check_regs();
    queue_write(8'h14, 32'h12345678, 4'b0101, 4'ha, 1'b0, 0, 0);
    run_queued();
    check_regs();

    // Past the end of the bank
    queue_write(8'h40, 32'hcafef00d, 4'hf, 4'h3, 1'b1, 0, 0);
    queue_write(8'hfc, 32'h0badf00d, 4'hf, 4'hc, 1'b0, 1, 0);
    run_queued();
    check_regs();

    // Hold B back and release it later
    b_mode = 1;
    for (int n = 0; n < 6; n++) begin
      queue_write(8'(4 * n + 32), 32'h01010101 * 32'(n + 1), 4'hf, 4'(n + 1), n[0], 0, 0);
    end
    fork
      drive_aw();
      drive_w();
      begin
        repeat (16) begin
          @(posedge clk);
          #2;
        end
        b_mode = 0;
      end
    join
    wait_idle();
    check_regs();

    // Long random mix with about one in eight out of range
    b_mode = 2;
    for (int n = 0; n < 200; n++) begin
      if (rand_bits(3) == 0) begin
        addr = 8'h40 | 8'(rand_bits(8));
      end else begin
        addr = 8'(rand_bits(6));
      end
      queue_write(addr, rand_bits(32), 4'(rand_bits(4)), 4'(rand_bits(4)), 1'(rand_bits(1)),
                  int'(rand_bits(2)), int'(rand_bits(2)));
    end
    run_queued();
    b_mode = 0;
    check_regs();

    $display("Summary: response errors %0d, register errors %0d, protocol errors %0d, timeouts %0d",
             resp_errs, reg_errs, proto_errs, timeouts);
    if (resp_errs + reg_errs + proto_errs + timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
axi_lite_pkg.sv
axi_full_pkg.sv
skid_buffer.sv
id_fifo.sv
axi_axil_reflect_wr.sv
axil_reg_bank.sv
axi_wr_bridge_top.sv
tb_axi_wr_bridge.sv

// File: Bender.yml
package:
  name: axi_wr_bridge

export_include_dirs:
  - .

sources:
  - files:
      - axi_lite_pkg.sv
      - axi_full_pkg.sv
      - skid_buffer.sv
      - id_fifo.sv
      - axi_axil_reflect_wr.sv
      - axil_reg_bank.sv
      - axi_wr_bridge_top.sv
  - target: test
    files:
      - tb_axi_wr_bridge.sv
